/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= mem_stage_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := sim passed

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# status comes from the search for the pass line
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* design/data_sram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_sram import lsu_pkg::*; #(
    // doubleword address bits
    parameter int MEM_AW  = 8,
    // response latency in cycles, at least 1
    parameter int MEM_LAT = 2
) (
    input  logic       clk,
    input  logic       rst_i,
    input  xlen_t      addr_i,
    input  logic       rd_en_i,
    input  logic       wr_en_i,
    input  xlen_t      wr_data_i,
    input  logic [7:0] wr_mask_i,
    output logic       rd_valid_o,
    output logic       wr_ok_o,
    output xlen_t      rd_data_o
);

    localparam int DEPTH = 1 << MEM_AW;
    // counter must reach MEM_LAT
    localparam int CNT_W = (MEM_LAT < 1) ? 1 : $clog2(MEM_LAT + 1);

    // storage, one doubleword per entry
    xlen_t              mem [DEPTH];

    logic [CNT_W-1:0]   lat_cnt;
    logic [MEM_AW-1:0]  word_idx;
    logic               req;
    logic               done;

    // byte address to doubleword index
    assign word_idx = addr_i[MEM_AW+2:3];

    assign req  = rd_en_i || wr_en_i;

    // completion once the counter has reached the latency
    assign done = req && (lat_cnt == CNT_W'(MEM_LAT));

    assign rd_valid_o = rd_en_i && done;
    assign wr_ok_o    = wr_en_i && done;

    // latency counter
    // zero on the first cycle of a request
    // clears at the completion edge so a held request restarts
    always_ff @(posedge clk) begin
        if (rst_i) begin
            lat_cnt <= '0;
        end else if (!req || done) begin
            lat_cnt <= '0;
        end else begin
            lat_cnt <= lat_cnt + 1'b1;
        end
    end

    // masked write, commits at the end of the completion cycle
    always_ff @(posedge clk) begin
        if (wr_ok_o) begin
            for (int b = 0; b < 8; b++) begin
                if (wr_mask_i[b]) begin
                    mem[word_idx][8*b +: 8] <= wr_data_i[8*b +: 8];
                end
            end
        end
    end

    // read data only shown in the completion cycle
    assign rd_data_o = rd_valid_o ? mem[word_idx] : '0;

endmodule

`default_nettype wire

/* design/ls_ctr.sv */
`timescale 1ns/1ps
`default_nettype none

module ls_ctr import lsu_pkg::*; (
    input  inst_t  instr_i,
    input  inst_t  instr_last_i,
    input  xlen_t  rs2_i,
    input  xlen_t  wb_data_i,
    output logic   rden_o,
    output logic   wren_o,
    output memop_e memop_o,
    output xlen_t  wr_data_o
);

    // full 32-bit encoding check on the low opcode bits
    logic cur_is_32;
    logic last_is_load;
    logic rs2_hits_rd;
    logic fwd_en;

    assign cur_is_32 = (instr_i[1:0] == 2'b11);

    // load / store enables
    assign rden_o = cur_is_32 && (instr_i[6:2] == OPC_LOAD);
    assign wren_o = cur_is_32 && (instr_i[6:2] == OPC_STORE);

    // width and signedness from funct3
    assign memop_o = memop_e'(instr_i[14:12]);

    // previous instruction was a load
    assign last_is_load = (instr_last_i[1:0] == 2'b11) && (instr_last_i[6:2] == OPC_LOAD);

    // store rs2 field against the load's rd
    assign rs2_hits_rd = (instr_i[24:20] == instr_last_i[11:7]);

    // load-to-store forwarding
    // the register file has not seen the loaded value yet
    assign fwd_en = last_is_load && rs2_hits_rd;

    assign wr_data_o = fwd_en ? wb_data_i : rs2_i;

endmodule

`default_nettype wire

/* design/lsu.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu import lsu_pkg::*; (
    // clk and rst_i drive no logic here
    // they are only a hook for the bound assertion checks
    input  logic       clk,
    input  logic       rst_i,
    input  logic       rden_i,
    input  logic       wren_i,
    input  memop_e     memop_i,
    input  xlen_t      addr_i,
    input  xlen_t      wr_data_i,
    output xlen_t      ls_res_o,
    output logic       ls_not_ok_o,
    output xlen_t      sram_addr_o,
    output logic       sram_rd_en_o,
    output logic       sram_wr_en_o,
    output xlen_t      sram_wr_data_o,
    output logic [7:0] sram_wr_mask_o,
    input  logic       sram_rd_valid_i,
    input  logic       sram_wr_ok_i,
    input  xlen_t      sram_rd_data_i
);

    // byte offset inside the doubleword
    logic [2:0] byte_off;
    // same offset in bits
    logic [5:0] bit_off;
    // store data replicated over its own width
    xlen_t      wr_rep;
    // low-aligned mask before shifting
    logic [7:0] mask_base;
    // read word with the addressed lane moved down to bit 0
    xlen_t      rd_lane;

    assign byte_off = addr_i[2:0];
    assign bit_off  = {byte_off, 3'b000};

    // request side straight through
    assign sram_addr_o  = addr_i;
    assign sram_rd_en_o = rden_i;
    assign sram_wr_en_o = wren_i;

    // stall while the enabled access has not completed
    assign ls_not_ok_o = (rden_i && !sram_rd_valid_i) || (wren_i && !sram_wr_ok_i);

    // store side
    // size is memop bits 1:0
    always_comb begin
        case (memop_i[1:0])
            2'b00: begin
                mask_base = 8'b0000_0001;
                wr_rep    = {8{wr_data_i[7:0]}};
            end
            2'b01: begin
                mask_base = 8'b0000_0011;
                wr_rep    = {4{wr_data_i[15:0]}};
            end
            2'b10: begin
                mask_base = 8'b0000_1111;
                wr_rep    = {2{wr_data_i[31:0]}};
            end
            default: begin
                mask_base = 8'b1111_1111;
                wr_rep    = wr_data_i;
            end
        endcase
    end

    // move mask and data onto the addressed lane
    // aligned accesses never spill past byte 7
    assign sram_wr_mask_o = wren_i ? (mask_base << byte_off) : 8'h00;
    assign sram_wr_data_o = wr_rep << bit_off;

    // load side
    assign rd_lane = sram_rd_data_i >> bit_off;

    // extension per memop, zero when no load
    always_comb begin
        ls_res_o = '0;
        if (rden_i) begin
            case (memop_i)
                MEM_B: begin
                    ls_res_o = {{(XLEN-8){rd_lane[7]}}, rd_lane[7:0]};
                end
                MEM_H: begin
                    ls_res_o = {{(XLEN-16){rd_lane[15]}}, rd_lane[15:0]};
                end
                MEM_W: begin
                    ls_res_o = {{(XLEN-32){rd_lane[31]}}, rd_lane[31:0]};
                end
                MEM_D: begin
                    ls_res_o = sram_rd_data_i;
                end
                MEM_BU: begin
                    ls_res_o = {{(XLEN-8){1'b0}}, rd_lane[7:0]};
                end
                MEM_HU: begin
                    ls_res_o = {{(XLEN-16){1'b0}}, rd_lane[15:0]};
                end
                MEM_WU: begin
                    ls_res_o = {{(XLEN-32){1'b0}}, rd_lane[31:0]};
                end
                // funct3 3'b111 is not a load, result stays zero
                default: begin
                    ls_res_o = '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    // data and address width
    parameter int XLEN = 64;

    // instruction width
    parameter int INST_LEN = 32;

    // one word of data or address
    typedef logic [XLEN-1:0] xlen_t;

    // raw instruction word
    typedef logic [INST_LEN-1:0] inst_t;

    // access width, straight from funct3
    // bit 2 set means zero extension on loads
    // bits 1:0 give log2 of the byte count
    typedef enum logic [2:0] {
        MEM_B  = 3'b000,
        MEM_H  = 3'b001,
        MEM_W  = 3'b010,
        MEM_D  = 3'b011,
        MEM_BU = 3'b100,
        MEM_HU = 3'b101,
        MEM_WU = 3'b110
    } memop_e;

    // major opcodes, instruction bits 6:2
    // the two low bits are always 2'b11 for 32-bit encodings
    localparam logic [4:0] OPC_LOAD  = 5'b00000;
    localparam logic [4:0] OPC_STORE = 5'b01000;

    // rv32/rv64 field positions used by the decoder
    // opcode 6:2, rd 11:7, funct3 14:12, rs2 24:20

endpackage

`default_nettype wire

/* design/mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage import lsu_pkg::*; #(
    parameter int MEM_AW  = 8,
    parameter int MEM_LAT = 2
) (
    input  logic  clk,
    input  logic  rst_i,
    input  inst_t instr_i,
    input  inst_t instr_last_i,
    input  xlen_t rs2_i,
    input  xlen_t wb_data_i,
    input  xlen_t addr_i,
    output xlen_t ls_res_o,
    output logic  ls_not_ok_o
);

    // decoder to lsu
    logic       rden;
    logic       wren;
    memop_e     memop;
    xlen_t      wr_data;

    // lsu to sram
    xlen_t      sram_addr;
    logic       sram_rd_en;
    logic       sram_wr_en;
    xlen_t      sram_wr_data;
    logic [7:0] sram_wr_mask;

    // sram back to lsu
    logic       sram_rd_valid;
    logic       sram_wr_ok;
    xlen_t      sram_rd_data;

    // instruction decode and forwarding
    ls_ctr u_ls_ctr (
        .instr_i      (instr_i),
        .instr_last_i (instr_last_i),
        .rs2_i        (rs2_i),
        .wb_data_i    (wb_data_i),
        .rden_o       (rden),
        .wren_o       (wren),
        .memop_o      (memop),
        .wr_data_o    (wr_data)
    );

    // lane placement, extension, stall
    lsu u_lsu (
        .clk             (clk),
        .rst_i           (rst_i),
        .rden_i          (rden),
        .wren_i          (wren),
        .memop_i         (memop),
        .addr_i          (addr_i),
        .wr_data_i       (wr_data),
        .ls_res_o        (ls_res_o),
        .ls_not_ok_o     (ls_not_ok_o),
        .sram_addr_o     (sram_addr),
        .sram_rd_en_o    (sram_rd_en),
        .sram_wr_en_o    (sram_wr_en),
        .sram_wr_data_o  (sram_wr_data),
        .sram_wr_mask_o  (sram_wr_mask),
        .sram_rd_valid_i (sram_rd_valid),
        .sram_wr_ok_i    (sram_wr_ok),
        .sram_rd_data_i  (sram_rd_data)
    );

    // fixed-latency data memory
    data_sram #(
        .MEM_AW  (MEM_AW),
        .MEM_LAT (MEM_LAT)
    ) u_data_sram (
        .clk        (clk),
        .rst_i      (rst_i),
        .addr_i     (sram_addr),
        .rd_en_i    (sram_rd_en),
        .wr_en_i    (sram_wr_en),
        .wr_data_i  (sram_wr_data),
        .wr_mask_i  (sram_wr_mask),
        .rd_valid_o (sram_rd_valid),
        .wr_ok_o    (sram_wr_ok),
        .rd_data_o  (sram_rd_data)
    );

endmodule

`default_nettype wire

/* flist.f */
design/lsu_pkg.sv
design/ls_ctr.sv
design/lsu.sv
design/data_sram.sv
design/mem_stage.sv
test/mem_stage_assertions.sv
test/mem_stage_tb.sv

/* test/mem_stage_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_assertions import lsu_pkg::*; (
    input logic   clk,
    input logic   rst_i,
    input logic   rden_i,
    input logic   wren_i,
    input memop_e memop_i,
    input xlen_t  addr_i,
    input logic   stall_i
);

    // address bits that must be zero for the access width
    logic [2:0] align_bits;

    always_comb begin
        case (memop_i[1:0])
            2'b00:   align_bits = 3'b000;
            2'b01:   align_bits = 3'b001;
            2'b10:   align_bits = 3'b011;
            default: align_bits = 3'b111;
        endcase
    end

    // one instruction is a load or a store, never both
    assert property (@(posedge clk) disable iff (rst_i) !(rden_i && wren_i))
        else $error("load and store enables high together");

    // naturally aligned accesses only
    assert property (@(posedge clk) disable iff (rst_i)
        (rden_i || wren_i) |-> ((addr_i[2:0] & align_bits) == 3'b000))
        else $error("misaligned access at %h", addr_i);

    // request held steady while stalled
    assert property (@(posedge clk) disable iff (rst_i)
        stall_i |=> ($stable(rden_i) && $stable(wren_i)
                     && $stable(memop_i) && $stable(addr_i)))
        else $error("request changed while stalled");

endmodule

bind lsu lsu_assertions u_lsu_assertions (
    .clk     (clk),
    .rst_i   (rst_i),
    .rden_i  (rden_i),
    .wren_i  (wren_i),
    .memop_i (memop_i),
    .addr_i  (addr_i),
    .stall_i (ls_not_ok_o)
);

`default_nettype wire

/* test/mem_stage_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage_tb import lsu_pkg::*; ();

    localparam int MEM_AW        = 8;
    localparam int MEM_LAT       = 2;
    localparam int STALL_TIMEOUT = 20;
    // addi x0, x0, 0
    localparam inst_t NOP        = 32'h0000_0013;

    // one row of stimulus plus expectation
    typedef struct {
        string name;
        inst_t instr;
        inst_t last;
        xlen_t rs2;
        xlen_t wb;
        xlen_t addr;
        xlen_t exp;
        int    lat;
    } entry_t;

    logic  clk;
    logic  rst_i;
    inst_t instr;
    inst_t instr_last;
    xlen_t rs2;
    xlen_t wb_data;
    xlen_t addr;
    xlen_t ls_res;
    logic  ls_not_ok;

    entry_t      table_q[$];
    // what the memory should hold after each store
    xlen_t       ref_mem [1 << MEM_AW];
    logic [31:0] rng_state  = 32'h02bb_f53d;
    int          word_errs  = 0;
    int          stall_errs = 0;
    int          timeouts   = 0;

    mem_stage #(
        .MEM_AW  (MEM_AW),
        .MEM_LAT (MEM_LAT)
    ) dut_i (
        .clk          (clk),
        .rst_i        (rst_i),
        .instr_i      (instr),
        .instr_last_i (instr_last),
        .rs2_i        (rs2),
        .wb_data_i    (wb_data),
        .addr_i       (addr),
        .ls_res_o     (ls_res),
        .ls_not_ok_o  (ls_not_ok)
    );

    // 40 ns period
    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // two draws per doubleword
    function automatic xlen_t rand_xlen();
        xlen_t v;
        rng_state = xorshift32(rng_state);
        v[63:32]  = rng_state;
        rng_state = xorshift32(rng_state);
        v[31:0]   = rng_state;
        return v;
    endfunction

    // I-type load, rs1 x1, imm 0
    function automatic inst_t make_load(input logic [4:0] rd, input memop_e op);
        return {12'h000, 5'd1, op, rd, OPC_LOAD, 2'b11};
    endfunction

    // S-type store, rs1 x1, imm 0
    function automatic inst_t make_store(input logic [4:0] rs2_idx, input memop_e op);
        return {7'h00, rs2_idx, 5'd1, op, 5'd0, OPC_STORE, 2'b11};
    endfunction

    // byte lanes from the offset upward, width 1 << funct3[1:0]
    function automatic void ref_store(input xlen_t a, input xlen_t d, input memop_e op);
        logic [2:0] f3;
        int         off;
        int         nbytes;
        f3     = op;
        off    = int'(a[2:0]);
        nbytes = 1 << f3[1:0];
        for (int b = 0; b < nbytes; b++) begin
            ref_mem[a[MEM_AW+2:3]][8*(off+b) +: 8] = d[8*b +: 8];
        end
    endfunction

    function automatic xlen_t ref_load(input xlen_t a, input memop_e op);
        logic [2:0] f3;
        int         off;
        int         nbytes;
        xlen_t      v;
        f3     = op;
        off    = int'(a[2:0]);
        nbytes = 1 << f3[1:0];
        v      = '0;
        for (int b = 0; b < nbytes; b++) begin
            v[8*b +: 8] = ref_mem[a[MEM_AW+2:3]][8*(off+b) +: 8];
        end
        // funct3 bit 2 clear means sign extension
        if (!f3[2]) begin
            for (int k = 8*nbytes; k < XLEN; k++) begin
                v[k] = v[8*nbytes-1];
            end
        end
        return v;
    endfunction

    task automatic add_row(input string name, input inst_t ins, input inst_t last,
                           input xlen_t r2, input xlen_t wb, input xlen_t a,
                           input xlen_t exp, input int lat);
        table_q.push_back('{name, ins, last, r2, wb, a, exp, lat});
    endtask

    task automatic add_load(input string name, input memop_e op, input xlen_t a);
        add_row(name, make_load(5'd10, op), NOP, '0, '0, a, ref_load(a, op), MEM_LAT);
    endtask

    // fwd marks the rows where the previous load's value must be stored
    task automatic add_store(input string name, input memop_e op, input xlen_t a,
                             input logic [4:0] rs2_idx, input inst_t last, input logic fwd);
        xlen_t r2;
        xlen_t wb;
        r2 = rand_xlen();
        wb = rand_xlen();
        ref_store(a, fwd ? wb : r2, op);
        add_row(name, make_store(rs2_idx, op), last, r2, wb, a, '0, MEM_LAT);
    endtask

    task automatic build_table();
        xlen_t bases [2];
        xlen_t a;
        bases[0] = 64'h40;
        // last doubleword of the array
        bases[1] = 64'h7f8;
        add_row("idle_after_reset", NOP, NOP, '0, '0, '0, '0, 0);
        // full doubleword, then every lane of every width
        foreach (bases[j]) begin
            add_store($sformatf("sd_%0h", bases[j]), MEM_D, bases[j], 5'd11, NOP, 1'b0);
            for (int off = 0; off < 8; off++) begin
                a = bases[j] + xlen_t'(off);
                add_load($sformatf("lb_%0h", a), MEM_B, a);
                add_load($sformatf("lbu_%0h", a), MEM_BU, a);
                if (off % 2 == 0) begin
                    add_load($sformatf("lh_%0h", a), MEM_H, a);
                    add_load($sformatf("lhu_%0h", a), MEM_HU, a);
                end
                if (off % 4 == 0) begin
                    add_load($sformatf("lw_%0h", a), MEM_W, a);
                    add_load($sformatf("lwu_%0h", a), MEM_WU, a);
                end
            end
            add_load($sformatf("ld_%0h", bases[j]), MEM_D, bases[j]);
        end
        add_row("idle_between", NOP, NOP, '0, '0, 64'h48, '0, 0);
        // partial stores touch only their lanes, neighbour word untouched
        add_store("sd_100", MEM_D, 64'h100, 5'd11, NOP, 1'b0);
        add_store("sd_108", MEM_D, 64'h108, 5'd11, NOP, 1'b0);
        add_store("sb_105", MEM_B, 64'h105, 5'd11, NOP, 1'b0);
        add_load("ld_100_a", MEM_D, 64'h100);
        add_store("sh_102", MEM_H, 64'h102, 5'd11, NOP, 1'b0);
        add_load("ld_100_b", MEM_D, 64'h100);
        add_store("sw_104", MEM_W, 64'h104, 5'd11, NOP, 1'b0);
        add_load("ld_100_c", MEM_D, 64'h100);
        add_store("sb_100", MEM_B, 64'h100, 5'd11, NOP, 1'b0);
        add_store("sh_106", MEM_H, 64'h106, 5'd11, NOP, 1'b0);
        add_load("ld_100_d", MEM_D, 64'h100);
        add_load("ld_108", MEM_D, 64'h108);
        // forwarding, previous load rd against store rs2
        add_store("fwd_hit_sd", MEM_D, 64'h180, 5'd7, make_load(5'd7, MEM_D), 1'b1);
        add_load("ld_fwd_hit", MEM_D, 64'h180);
        add_store("fwd_miss_rd", MEM_D, 64'h180, 5'd7, make_load(5'd8, MEM_D), 1'b0);
        add_load("ld_fwd_miss", MEM_D, 64'h180);
        // addi x7, x0, 1 writes rd 7 but is no load
        add_store("fwd_not_load", MEM_D, 64'h180, 5'd7, 32'h0010_0393, 1'b0);
        add_load("ld_fwd_not_load", MEM_D, 64'h180);
        add_store("fwd_hit_sw", MEM_W, 64'h184, 5'd7, make_load(5'd7, MEM_W), 1'b1);
        add_load("ld_fwd_sw", MEM_D, 64'h180);
        add_row("idle_end", NOP, NOP, '0, '0, '0, '0, 0);
    endtask

    task automatic check_word(input string name, input xlen_t exp, input xlen_t act);
        if (act !== exp) begin
            $display("error %s: expected %h, actual %h", name, exp, act);
            word_errs++;
        end
    endtask

    task automatic check_stall(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error %s stall: expected %b, actual %b", name, exp, act);
            stall_errs++;
        end
    endtask

    initial begin
        int   cyc;
        logic done;
        rst_i      <= 1'b1;
        instr      <= NOP;
        instr_last <= NOP;
        rs2        <= '0;
        wb_data    <= '0;
        addr       <= '0;
        build_table();
        repeat (16) @(posedge clk);
        rst_i <= 1'b0;
        for (int i = 0; i < table_q.size(); i++) begin
            @(posedge clk);
            instr      <= table_q[i].instr;
            instr_last <= table_q[i].last;
            rs2        <= table_q[i].rs2;
            wb_data    <= table_q[i].wb;
            addr       <= table_q[i].addr;
            cyc  = 0;
            done = 1'b0;
            // stall high for lat cycles, low in the completion cycle
            while (!done && timeouts == 0) begin
                @(negedge clk);
                check_stall(table_q[i].name, cyc < table_q[i].lat, ls_not_ok);
                if (!ls_not_ok) begin
                    done = 1'b1;
                end else begin
                    cyc++;
                    if (cyc >= STALL_TIMEOUT) begin
                        $display("stall never cleared in %s after %0d cycles",
                                 table_q[i].name, cyc);
                        timeouts++;
                    end
                end
            end
            if (timeouts != 0) begin
                break;
            end
            check_word(table_q[i].name, table_q[i].exp, ls_res);
        end
        $display("errors: result %0d, stall %0d, timeout %0d", word_errs, stall_errs, timeouts);
        if (word_errs == 0 && stall_errs == 0 && timeouts == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
